/* Makefile */
TOP = ps2_mouse_nofifo_tb

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -f ps2_mouse_nofifo.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | awk '{print} /All checks passed/{ok=1} END{exit !ok}'

clean:
	rm -rf obj_dir

.PHONY: help test clean

/* ps2_line_sync.sv */
// ----------------------------------------------------------------------
// input synchronizer for both ps2 lines, falling-edge strobe on clock
// ----------------------------------------------------------------------
`include "ps2_params.svh"
`default_nettype none

module ps2_line_sync import ps2_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire ps2_line_t ps2_in,   // raw pin levels
  output ps2_line_t      line,     // synchronized levels
  output logic           clk_fall  // one cycle per device clock fall
);

  localparam int N = `PS2_SYNC_STAGES;

  logic [N-1:0] clk_sync; // shift chain, [N-1] is the stable end
  logic [N-1:0] dat_sync;
  logic         clk_prev; // extra stage for edge detect

  // --------------------------------------------------------------------
  // synchronizer chains
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_sync <= '1; // idle high, no false edge out of reset
      dat_sync <= '1;
    end else begin
      clk_sync <= {clk_sync[N-2:0], ps2_in.clk};
      dat_sync <= {dat_sync[N-2:0], ps2_in.dat};
    end
  end

  assign line.clk = clk_sync[N-1];
  assign line.dat = dat_sync[N-1];

  // --------------------------------------------------------------------
  // falling edge, registered
  // raw fall -> strobe high three clocks later
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_prev <= 1'b1;
      clk_fall <= 1'b0;
    end else begin
      clk_prev <= clk_sync[N-1];
      clk_fall <= clk_prev & ~clk_sync[N-1]; // high then low
    end
  end

endmodule

`default_nettype wire

/* ps2_mouse.sv */
// ----------------------------------------------------------------------
// ps2 mouse controller core
// synchronizer, receiver, transmitter and line ownership
// ----------------------------------------------------------------------
`default_nettype none

module ps2_mouse import ps2_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic [7:0] the_command,
  input  wire logic       send_command,
  output logic [7:0]      received_data,
  output logic            received_data_en,
  output logic            frame_error,
  output logic            command_was_sent,
  output logic            error_communication_timed_out,
  input  wire ps2_line_t  ps2_in,    // raw pins
  output ps2_line_t       ps2_drive  // open-drain enables
);

  ps2_line_t     line;       // synced pins
  logic          clk_fall;
  logic          busy;       // tx owns the bus
  ps2_rx_frame_t frame;
  logic          good_frame;
  logic [7:0]    last_byte;  // held for the processor

  // --------------------------------------------------------------------
  // blocks
  // --------------------------------------------------------------------
  ps2_line_sync u_sync (
    .clk      (clk),
    .rst      (rst),
    .ps2_in   (ps2_in),
    .line     (line),
    .clk_fall (clk_fall)
  );

  ps2_rx u_rx (
    .clk      (clk),
    .rst      (rst),
    .line     (line),
    .clk_fall (clk_fall),
    .hold     (busy), // never decode our own command
    .frame    (frame)
  );

  ps2_tx u_tx (
    .clk       (clk),
    .rst       (rst),
    .command   (the_command),
    .send      (send_command),
    .line      (line),
    .clk_fall  (clk_fall),
    .drive     (ps2_drive),
    .busy      (busy),
    .sent      (command_was_sent),
    .timed_out (error_communication_timed_out)
  );

  // --------------------------------------------------------------------
  // receive side
  // --------------------------------------------------------------------
  assign good_frame = frame.valid & ~frame.frame_err;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_byte <= '0;
    end else if (good_frame) begin
      last_byte <= frame.data;
    end
  end

  // new byte shows in the same cycle as its strobe
  assign received_data    = good_frame ? frame.data : last_byte;
  assign received_data_en = good_frame;
  assign frame_error      = frame.valid & frame.frame_err; // bad byte dropped

endmodule

`default_nettype wire

/* ps2_mouse_nofifo.f */
+incdir+.
ps2_pkg.sv
ps2_line_sync.sv
ps2_rx.sv
ps2_tx.sv
ps2_mouse.sv
ps2_mouse_nofifo.sv
ps2_mouse_nofifo_checker.sv
ps2_mouse_nofifo_tb.sv

/* ps2_mouse_nofifo.sv */
// ----------------------------------------------------------------------
// ps2 mouse port, processor side strobe/irq interface, no fifo
// ----------------------------------------------------------------------
`default_nettype none

module ps2_mouse_nofifo import ps2_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic [7:0] writedata,             // command byte
  input  wire logic       write,                 // send it, ignored when busy
  output logic [7:0]      readdata,              // last good byte
  output logic            irq,                   // byte arrived
  output logic            command_was_sent,
  output logic            error_sending_command,
  output logic            frame_error,           // parity or stop bad
  input  wire ps2_line_t  ps2_in,                // pin levels
  output ps2_line_t       ps2_drive              // 1 pulls the pin low
);

  // core, renamed to processor names
  ps2_mouse mouse (
    .clk                           (clk),
    .rst                           (rst),
    .the_command                   (writedata),
    .send_command                  (write),
    .received_data                 (readdata),
    .received_data_en              (irq),
    .frame_error                   (frame_error),
    .command_was_sent              (command_was_sent),
    .error_communication_timed_out (error_sending_command),
    .ps2_in                        (ps2_in),
    .ps2_drive                     (ps2_drive)
  );

endmodule

`default_nettype wire

/* ps2_mouse_nofifo_checker.sv */
// ----------------------------------------------------------------------
// bound assertions on the ps2 port handshake and line drive
// ----------------------------------------------------------------------
`default_nettype none

module ps2_mouse_nofifo_checker import ps2_pkg::*; (
  input wire logic      clk,
  input wire logic      rst,
  input wire logic      irq,
  input wire logic      frame_error,
  input wire logic      command_was_sent,
  input wire logic      error_sending_command,
  input wire ps2_line_t ps2_drive
);

  logic fired = 1'b0; // sticky, read by the testbench

  // a byte is either good or bad, never both
  a_rx_result: assert property (@(posedge clk) disable iff (rst) !(irq && frame_error))
    else begin
      fired = 1'b1;
      $error("irq and frame_error high together");
    end

  a_tx_result: assert property (@(posedge clk) disable iff (rst)
                                !(command_was_sent && error_sending_command))
    else begin
      fired = 1'b1;
      $error("both command results high together");
    end

  a_reset_drive: assert property (@(posedge clk) $past(rst) |-> (ps2_drive == 2'b00))
    else begin
      fired = 1'b1;
      $error("line drive asserted during reset");
    end

  // clock pulled while data pulled would corrupt a frame in flight
  a_drive_pair: assert property (@(posedge clk) disable iff (rst)
                                 !(ps2_drive.clk && ps2_drive.dat))
    else begin
      fired = 1'b1;
      $error("clock and data drive asserted together");
    end

endmodule

bind ps2_mouse_nofifo ps2_mouse_nofifo_checker bus_checks (
  .clk                   (clk),
  .rst                   (rst),
  .irq                   (irq),
  .frame_error           (frame_error),
  .command_was_sent      (command_was_sent),
  .error_sending_command (error_sending_command),
  .ps2_drive             (ps2_drive)
);

`default_nettype wire

/* ps2_mouse_nofifo_tb.sv */
// ----------------------------------------------------------------------
// testbench for the ps2 mouse port
// behavioural mouse on the wires, directed tests, cycle limit
// ----------------------------------------------------------------------
`include "ps2_params.svh"
`default_nettype none

module ps2_mouse_nofifo_tb import ps2_pkg::*; ();

  localparam int HALF       = 20; // device clock half period in system clocks
  localparam int NUM_FRAMES = 13; // 11 received plus 2 commands clocked out
  localparam int NUM_CMDS   = 3;
  localparam int LIMIT = (NUM_FRAMES * 11 * 40
                          + NUM_CMDS * (`PS2_INHIBIT_CYCLES + `PS2_TIMEOUT_CYCLES)) * 5 / 4;

  logic        clk;
  logic        rst;
  logic [7:0]  writedata;
  logic        write;
  logic [7:0]  readdata;
  logic        irq;
  logic        command_was_sent;
  logic        error_sending_command;
  logic        frame_error;
  ps2_line_t   ps2_in;
  ps2_line_t   ps2_drive;
  logic        dev_clk;              // mouse side drive where 0 pulls low
  logic        dev_dat;
  logic [16:0] lfsr = 17'd95229;
  int          cycles = 0;
  int          irq_cnt = 0;          // pulse counters
  int          ferr_cnt = 0;
  int          sent_cnt = 0;
  int          terr_cnt = 0;
  logic [7:0]  irq_byte;             // readdata seen with last irq
  logic [7:0]  last_good;            // last byte sent with good framing

  // open-drain wires where either side pulls low
  assign ps2_in = {dev_clk & ~ps2_drive.clk, dev_dat & ~ps2_drive.dat};

  ps2_mouse_nofifo UUT (
    .clk                   (clk),
    .rst                   (rst),
    .writedata             (writedata),
    .write                 (write),
    .readdata              (readdata),
    .irq                   (irq),
    .command_was_sent      (command_was_sent),
    .error_sending_command (error_sending_command),
    .frame_error           (frame_error),
    .ps2_in                (ps2_in),
    .ps2_drive             (ps2_drive)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------
  // monitors and run limit
  // --------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst) begin
      if (irq) begin
        irq_cnt++;
        irq_byte = readdata; // byte valid with its strobe
      end
      if (frame_error) ferr_cnt++;
      if (command_was_sent) sent_cnt++;
      if (error_sending_command) terr_cnt++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (UUT.bus_checks.fired) begin
      $display("a bound assertion on the DUT ports fired");
      $display("Checks failed");
      $fatal(1, "checker");
    end else if (cycles > LIMIT) begin
      $display("run did not finish within %0d cycles", LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]}; // x^17 + x^14 + 1
  endfunction

  task automatic next_byte(output logic [7:0] b);
    repeat (8) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]}; // one step per bit
    end
  endtask

  function automatic logic odd_parity(input logic [7:0] b);
    int         ones;
    logic [7:0] v;
    ones = 0;
    v    = b;
    repeat (8) begin
      if (v[0]) ones++;
      v = v >> 1;
    end
    return (ones % 2) == 0; // total ones incl parity must be odd
  endfunction

  task automatic expect_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("FAILED time %0t %s expected %0h actual %0h",
               $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic expect_true(input string what, input logic cond);
    assert (cond) else begin
      $display("error at time %0t: %s", $time, what);
      $display("Checks failed");
      $fatal(1, "check failed");
    end
  endtask

  // --------------------------------------------------------------------
  // mouse model
  // --------------------------------------------------------------------
  task automatic device_clock_pulse();
    repeat (HALF) @(posedge clk);
    dev_clk <= 1'b0;
    repeat (HALF) @(posedge clk);
    dev_clk <= 1'b1;
  endtask

  task automatic device_send_frame(input logic [7:0] b, input logic par, input logic stop);
    logic [10:0] bits;
    bits = {stop, par, b, 1'b0}; // start bit first on the wire
    repeat (11) begin
      @(posedge clk);
      dev_dat <= bits[0]; // change while clock is high
      bits = bits >> 1;
      device_clock_pulse();
    end
    @(posedge clk);
    dev_dat <= 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  // host-to-device sequence of inhibit, start, 8 data, parity, stop and ack
  task automatic device_take_command(output logic [7:0] data, output logic par,
                                     output logic stop);
    int         held;
    int         waited;
    logic [9:0] bits;
    held   = 0;
    waited = 0;
    while (!ps2_drive.clk && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    while (ps2_drive.clk) begin
      held++;
      @(negedge clk);
    end
    expect_true("clock inhibit shorter than required", held >= `PS2_INHIBIT_CYCLES);
    expect_value("ps2_drive.dat", 32'd1, 32'(ps2_drive.dat)); // start bit
    repeat (10) begin
      device_clock_pulse();
      @(negedge clk);
      bits = {ps2_in.dat, bits[9:1]}; // read on the rising edge
    end
    @(posedge clk);
    dev_dat <= 1'b0; // ack
    device_clock_pulse();
    @(posedge clk);
    dev_dat <= 1'b1;
    data = bits[7:0];
    par  = bits[8];
    stop = bits[9];
  endtask

  task automatic issue_write(input logic [7:0] b);
    @(posedge clk);
    writedata <= b;
    write     <= 1'b1;
    @(posedge clk);
    write <= 1'b0;
  endtask

  task automatic wait_completion(input int base, input int limit);
    int n;
    n = 0;
    while (sent_cnt + terr_cnt == base && n < limit) begin
      @(negedge clk);
      n++;
    end
    expect_true("no completion pulse after a write", sent_cnt + terr_cnt > base);
  endtask

  // --------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------
  task automatic reset_state_is_idle();
    @(negedge clk);
    expect_value("irq", 32'd0, 32'(irq));
    expect_value("frame_error", 32'd0, 32'(frame_error));
    expect_value("command_was_sent", 32'd0, 32'(command_was_sent));
    expect_value("error_sending_command", 32'd0, 32'(error_sending_command));
    expect_value("ps2_drive", 32'd0, 32'(ps2_drive));
    expect_value("readdata", 32'd0, 32'(readdata));
  endtask

  task automatic receive_good_bytes();
    logic [7:0] b;
    int         irq0;
    int         ferr0;
    repeat (8) begin
      next_byte(b);
      irq0  = irq_cnt;
      ferr0 = ferr_cnt;
      device_send_frame(b, odd_parity(b), 1'b1);
      last_good = b;
      expect_value("irq pulses", 32'(irq0 + 1), 32'(irq_cnt));
      expect_value("frame_error pulses", 32'(ferr0), 32'(ferr_cnt));
      expect_value("readdata at irq", 32'(b), 32'(irq_byte));
      expect_value("readdata", 32'(b), 32'(readdata));
    end
  endtask

  // first bad parity, then a low stop bit
  task automatic receive_bad_frames();
    logic [7:0] b;
    int         irq0;
    int         ferr0;
    for (int k = 0; k < 2; k++) begin
      next_byte(b);
      irq0  = irq_cnt;
      ferr0 = ferr_cnt;
      device_send_frame(b, (k == 0) ? ~odd_parity(b) : odd_parity(b), k == 0);
      expect_value("frame_error pulses", 32'(ferr0 + 1), 32'(ferr_cnt));
      expect_value("irq pulses", 32'(irq0), 32'(irq_cnt));
      expect_value("readdata", 32'(last_good), 32'(readdata));
    end
  endtask

  task automatic send_one_command();
    logic [7:0] cmd;
    logic [7:0] data;
    logic       par;
    logic       stop;
    int         sent0;
    int         terr0;
    next_byte(cmd);
    sent0 = sent_cnt;
    terr0 = terr_cnt;
    issue_write(cmd);
    device_take_command(data, par, stop);
    wait_completion(sent0 + terr0, 100);
    repeat (20) @(negedge clk);
    expect_value("command byte at mouse", 32'(cmd), 32'(data));
    expect_value("parity bit at mouse", 32'(odd_parity(cmd)), 32'(par));
    expect_value("stop bit at mouse", 32'd1, 32'(stop));
    expect_value("command_was_sent pulses", 32'(sent0 + 1), 32'(sent_cnt));
    expect_value("error_sending_command pulses", 32'(terr0), 32'(terr_cnt));
  endtask

  task automatic time_out_silent_device();
    logic [7:0] b;
    int         sent0;
    int         terr0;
    int         irq0;
    next_byte(b);
    sent0 = sent_cnt;
    terr0 = terr_cnt;
    issue_write(b); // mouse never clocks
    wait_completion(sent0 + terr0, `PS2_INHIBIT_CYCLES + `PS2_TIMEOUT_CYCLES + 100);
    repeat (20) @(negedge clk);
    expect_value("error_sending_command pulses", 32'(terr0 + 1), 32'(terr_cnt));
    expect_value("command_was_sent pulses", 32'(sent0), 32'(sent_cnt));
    expect_value("ps2_drive", 32'd0, 32'(ps2_drive));
    next_byte(b);
    irq0 = irq_cnt;
    device_send_frame(b, odd_parity(b), 1'b1);
    last_good = b;
    expect_value("irq pulses", 32'(irq0 + 1), 32'(irq_cnt));
    expect_value("readdata", 32'(b), 32'(readdata));
  endtask

  task automatic ignore_busy_write();
    logic [7:0] first;
    logic [7:0] data;
    logic       par;
    logic       stop;
    int         sent0;
    int         terr0;
    next_byte(first);
    sent0 = sent_cnt;
    terr0 = terr_cnt;
    issue_write(first);
    fork
      device_take_command(data, par, stop);
      begin
        repeat (100) @(posedge clk);
        issue_write(~first); // lands inside the inhibit window
      end
    join
    wait_completion(sent0 + terr0, 100);
    repeat (200) @(negedge clk);
    expect_value("command byte at mouse", 32'(first), 32'(data));
    expect_value("command_was_sent pulses", 32'(sent0 + 1), 32'(sent_cnt));
    expect_value("error_sending_command pulses", 32'(terr0), 32'(terr_cnt));
    expect_value("ps2_drive", 32'd0, 32'(ps2_drive)); // no second command
  endtask

  initial begin
    rst       = 1'b1;
    write     = 1'b0;
    writedata = 8'h00;
    dev_clk   = 1'b1;
    dev_dat   = 1'b1;
    last_good = 8'h00;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    reset_state_is_idle();
    receive_good_bytes();
    receive_bad_frames();
    send_one_command();
    time_out_silent_device();
    ignore_busy_write();
    if (UUT.bus_checks.fired) begin
      $display("Checks failed");
      $fatal(1, "checker");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* ps2_params.svh */
// ----------------------------------------------------------------------
// timing counts for the ps2 mouse controller
// ----------------------------------------------------------------------
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

`default_nettype none

// host holds clock low this many system clocks before a command
`define PS2_INHIBIT_CYCLES 400

// max wait for each device clock edge while sending
`define PS2_TIMEOUT_CYCLES 4000

// flops per line in the input synchronizer
`define PS2_SYNC_STAGES 2

`default_nettype wire

`endif

/* ps2_pkg.sv */
// ----------------------------------------------------------------------
// shared types for the ps2 mouse controller
// line level / drive-enable pair and the receiver result
// ----------------------------------------------------------------------
`default_nettype none

package ps2_pkg;

  // one bit per ps2 wire
  // used for sampled levels and for pull-low enables
  typedef struct packed {
    logic clk; // ps2 clock line
    logic dat; // ps2 data line
  } ps2_line_t;

  // result of one device-to-host frame
  typedef struct packed {
    logic [7:0] data;      // received byte, lsb sent first on the wire
    logic       valid;     // one-cycle strobe at end of frame
    logic       frame_err; // bad start, parity or stop
  } ps2_rx_frame_t;

endpackage

`default_nettype wire

/* ps2_rx.sv */
// ----------------------------------------------------------------------
// device-to-host frame receiver
// start, 8 data bits lsb first, odd parity, stop
// ----------------------------------------------------------------------
`default_nettype none

module ps2_rx import ps2_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire ps2_line_t line,     // synchronized lines
  input  wire logic      clk_fall, // sample strobe
  input  wire logic      hold,     // transmitter owns the bus
  output ps2_rx_frame_t  frame
);

  localparam logic [3:0] STOP_BIT = 4'd10; // bit index of stop

  logic [3:0]    bit_cnt;  // 0 start, 1..8 data, 9 parity, 10 stop
  logic [8:0]    shift_q;  // parity & data, newest bit on top
  logic          start_q;  // start bit as sampled, should be 0
  logic          bad;      // any check failed
  ps2_rx_frame_t frame_q;

  // odd parity means data + parity has an odd number of ones
  assign bad = start_q | ~(^shift_q) | ~line.dat; // stop is on line now

  // --------------------------------------------------------------------
  // bit counter and result strobe
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt           <= '0;
      frame_q.valid     <= 1'b0;
      frame_q.frame_err <= 1'b0;
    end else begin
      frame_q.valid <= 1'b0; // pulse only
      if (hold) begin
        bit_cnt <= '0; // own transmission, ignore
      end else if (clk_fall) begin
        if (bit_cnt == STOP_BIT) begin
          bit_cnt           <= '0;
          frame_q.valid     <= 1'b1;
          frame_q.frame_err <= bad;
          frame_q.data      <= shift_q[7:0];
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // data path
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (clk_fall && !hold) begin
      if (bit_cnt == 4'd0) begin
        start_q <= line.dat;
      end else if (bit_cnt != STOP_BIT) begin
        shift_q <= {line.dat, shift_q[8:1]}; // lsb arrives first
      end
    end
  end

  assign frame = frame_q;

endmodule

`default_nettype wire

/* ps2_tx.sv */
// ----------------------------------------------------------------------
// host-to-device command transmitter
// inhibit, request-to-send, data/parity/stop, ack, timeout
// ----------------------------------------------------------------------
`include "ps2_params.svh"
`default_nettype none

module ps2_tx import ps2_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic [7:0] command,   // byte to send
  input  wire logic       send,      // write strobe, taken only when idle
  input  wire ps2_line_t  line,      // synchronized lines
  input  wire logic       clk_fall,  // device clock fall
  output ps2_line_t       drive,     // 1 = pull line low
  output logic            busy,
  output logic            sent,      // ack seen
  output logic            timed_out  // no edge or no ack
);

  localparam int MAX_CNT = (`PS2_TIMEOUT_CYCLES > `PS2_INHIBIT_CYCLES) ?
                           `PS2_TIMEOUT_CYCLES : `PS2_INHIBIT_CYCLES;
  localparam int TIMER_W = $clog2(MAX_CNT + 1);
  localparam logic [TIMER_W-1:0] INHIBIT_LAST = TIMER_W'(`PS2_INHIBIT_CYCLES - 1);
  localparam logic [TIMER_W-1:0] TIMEOUT_LAST = TIMER_W'(`PS2_TIMEOUT_CYCLES - 1);
  localparam logic [3:0]         LAST_BIT     = 4'd9; // stop presented here

  typedef enum logic [2:0] {
    S_IDLE,
    S_INHIBIT,  // clock held low
    S_REQUEST,  // data low, clock released, wait for device
    S_BITS,     // data, parity, stop
    S_ACK_WAIT, // device pulls data low
    S_DONE      // one cycle, result pulse
  } tx_state_t;

  tx_state_t          state;
  logic [TIMER_W-1:0] timer;    // inhibit length or edge timeout
  logic [3:0]         bit_cnt;
  logic [9:0]         tx_shift; // stop, parity, data lsb first
  logic               err_q;    // result of this command
  ps2_line_t          drive_q;
  logic               dev_wait; // waiting on a device clock

  assign dev_wait = (state == S_REQUEST) || (state == S_BITS) || (state == S_ACK_WAIT);

  // --------------------------------------------------------------------
  // control FSM
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      timer   <= '0;
      bit_cnt <= '0;
      err_q   <= 1'b0;
      drive_q <= '0;
    end else begin
      case (state)
        S_IDLE: if (send) begin
          state       <= S_INHIBIT;
          drive_q.clk <= 1'b1; // inhibit starts next cycle
          timer       <= '0;
          err_q       <= 1'b0;
        end
        S_INHIBIT: if (timer == INHIBIT_LAST) begin
          state       <= S_REQUEST;
          drive_q.clk <= 1'b0;
          drive_q.dat <= 1'b1; // start bit
          timer       <= '0;
        end else begin
          timer <= timer + 1'b1;
        end
        S_REQUEST, S_BITS, S_ACK_WAIT: begin
          if (clk_fall) begin
            timer <= '0; // edge seen, restart watchdog
            if (state == S_ACK_WAIT) begin
              state <= S_DONE;
              err_q <= line.dat; // high here means no ack
            end else begin
              drive_q.dat <= ~tx_shift[0]; // next bit, low for a 0
              bit_cnt     <= (state == S_REQUEST) ? 4'd1 : bit_cnt + 4'd1;
              if (state == S_REQUEST) begin
                state <= S_BITS;
              end else if (bit_cnt == LAST_BIT) begin
                state <= S_ACK_WAIT; // stop is out, line released
              end
            end
          end else if (timer == TIMEOUT_LAST) begin
            state   <= S_DONE;
            err_q   <= 1'b1;
            drive_q <= '0; // let go of both lines
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: begin
          state   <= S_IDLE;
          drive_q <= '0;
        end
      endcase
    end
  end

  // shift register, loaded on accepted write
  always_ff @(posedge clk) begin
    if (state == S_IDLE && send) begin
      tx_shift <= {1'b1, ~(^command), command};
    end else if (clk_fall && dev_wait && state != S_ACK_WAIT) begin
      tx_shift <= {1'b0, tx_shift[9:1]};
    end
  end

  assign drive     = drive_q;
  assign busy      = (state != S_IDLE);
  assign sent      = (state == S_DONE) & ~err_q;
  assign timed_out = (state == S_DONE) & err_q;

endmodule

`default_nettype wire
